// ==== pcm_decoder_pkg.sv ====
package pcm_decoder_pkg;

  // ------------------------------------------------------------------------
  // Bus widths
  // ------------------------------------------------------------------------
  typedef logic [12:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0]  byte_en_t;

  // ------------------------------------------------------------------------
  // Mode codes
  // ------------------------------------------------------------------------
  typedef logic [1:0] code_mode_t;

  localparam code_mode_t CODE_NRZL = 2'd0;
  localparam code_mode_t CODE_NRZM = 2'd1;
  localparam code_mode_t CODE_NRZS = 2'd2;

  typedef logic [2:0] derand_mode_t;

  localparam derand_mode_t DERAND_OFF    = 3'd0;
  localparam derand_mode_t DERAND_RNRZ15 = 3'd1;
  localparam derand_mode_t DERAND_RNRZ9  = 3'd2;
  localparam derand_mode_t DERAND_RNRZ11 = 3'd3;
  localparam derand_mode_t DERAND_RNRZ17 = 3'd4;
  localparam derand_mode_t DERAND_RNRZ23 = 3'd5;

  // Long enough for the RNRZ23 taps
  localparam int DERAND_HIST_LEN = 23;

  // ------------------------------------------------------------------------
  // Control register
  // ------------------------------------------------------------------------
  localparam bus_addr_t DEC_CONTROL_ADDR = 13'd0;

  localparam int CTRL_CODE_MODE_LSB  = 0;
  localparam int CTRL_BIPHASE_BIT    = 2;
  localparam int CTRL_DERAND_LSB     = 4;
  localparam int CTRL_INVERT_BIT     = 8;
  localparam int CTRL_CLK_SEL_BIT    = 9;
  localparam int CTRL_CLK_PHASE_LSB  = 12;
  localparam int CTRL_INPUT_SEL_LSB  = 16;
  localparam int CTRL_FIFO_RESET_BIT = 24;

  // Defined fields only, everything else reads back as zero
  localparam bus_data_t CTRL_READ_MASK = 32'h0103_3377;

  typedef struct packed {
    code_mode_t   code_mode;
    logic         biphase;
    derand_mode_t derand_mode;
    logic         data_invert;
    logic         clock_select;
    logic [1:0]   clk_phase;
    logic [1:0]   input_select;
    logic         fifo_reset;
  } decoder_config_s;

  // One bit moving between data path stages
  typedef struct packed {
    logic strobe;
    logic value;
  } pcm_bit_s;

  typedef enum logic {
    FIRST_HALF  = 1'b0,
    SECOND_HALF = 1'b1
  } biphase_phase_e;

endpackage

// ==== pcm_decoder_regs.sv ====
`timescale 1ns/100ps

module pcm_decoder_regs (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              cs,
  input  pcm_decoder_pkg::byte_en_t         wr,
  input  pcm_decoder_pkg::bus_addr_t        addr,
  input  pcm_decoder_pkg::bus_data_t        din,
  output pcm_decoder_pkg::bus_data_t        dout,
  output pcm_decoder_pkg::decoder_config_s  cfg
);

  import pcm_decoder_pkg::*;

  bus_data_t ctrl_q;
  bus_data_t ctrl_masked;
  logic      hit;

  assign hit = cs && (addr == DEC_CONTROL_ADDR);

  // ------------------------------------------------------------------------
  // Control word, one byte lane per strobe bit
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ctrl_q <= '0;
    end else if (hit) begin
      for (int lane = 0; lane < $bits(byte_en_t); lane++) begin
        if (wr[lane]) begin
          ctrl_q[lane*8 +: 8] <= din[lane*8 +: 8];
        end
      end
    end
  end

  assign ctrl_masked = ctrl_q & CTRL_READ_MASK;

  // Readback is combinational
  assign dout = hit ? ctrl_masked : '0;

  // ------------------------------------------------------------------------
  // Field unpacking
  // ------------------------------------------------------------------------
  always_comb begin
    cfg.code_mode    = ctrl_q[CTRL_CODE_MODE_LSB +: $bits(code_mode_t)];
    cfg.biphase      = ctrl_q[CTRL_BIPHASE_BIT];
    cfg.derand_mode  = ctrl_q[CTRL_DERAND_LSB +: $bits(derand_mode_t)];
    cfg.data_invert  = ctrl_q[CTRL_INVERT_BIT];
    cfg.clock_select = ctrl_q[CTRL_CLK_SEL_BIT];
    cfg.clk_phase    = ctrl_q[CTRL_CLK_PHASE_LSB +: 2];
    cfg.input_select = ctrl_q[CTRL_INPUT_SEL_LSB +: 2];
    cfg.fifo_reset   = ctrl_q[CTRL_FIFO_RESET_BIT];
  end

endmodule

// ==== biphase_to_nrz.sv ====
`timescale 1ns/100ps

module biphase_to_nrz (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       symb_clk_en,
  input  logic                       biphase,
  input  logic                       symb,
  output pcm_decoder_pkg::pcm_bit_s  nrz_bit,
  output logic                       bit_tick
);

  import pcm_decoder_pkg::*;

  biphase_phase_e phase_q;
  logic           half_q;
  logic           strobe_q;
  logic           value_q;

  // A symbol is complete on every strobe in NRZ mode, on the second half in biphase
  assign bit_tick = symb_clk_en && (!biphase || (phase_q == SECOND_HALF));

  // ------------------------------------------------------------------------
  // Half-bit phase tracking
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      phase_q <= FIRST_HALF;
    end else if (!biphase) begin
      phase_q <= FIRST_HALF;
    end else if (symb_clk_en) begin
      phase_q <= (phase_q == FIRST_HALF) ? SECOND_HALF : FIRST_HALF;
    end
  end

  // First half of biphase-L carries the data level
  always_ff @(posedge clk) begin
    if (symb_clk_en && biphase && (phase_q == FIRST_HALF)) begin
      half_q <= symb;
    end
  end

  // ------------------------------------------------------------------------
  // Output bit
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      strobe_q <= 1'b0;
      value_q  <= 1'b0;
    end else begin
      strobe_q <= bit_tick;
      if (bit_tick) begin
        value_q <= biphase ? half_q : symb;
      end
    end
  end

  assign nrz_bit.strobe = strobe_q;
  assign nrz_bit.value  = value_q;

endmodule

// ==== mark_space_decode.sv ====
`timescale 1ns/100ps

module mark_space_decode (
  input  logic                        clk,
  input  logic                        reset,
  input  pcm_decoder_pkg::code_mode_t code_mode,
  input  pcm_decoder_pkg::pcm_bit_s   in_bit,
  output pcm_decoder_pkg::pcm_bit_s   out_bit
);

  import pcm_decoder_pkg::*;

  logic prev_q;
  logic strobe_q;
  logic value_q;
  logic decoded;

  // Mark codes a one as a transition, space codes a zero as one
  always_comb begin
    case (code_mode)
      CODE_NRZM: decoded = in_bit.value ^ prev_q;
      CODE_NRZS: decoded = ~(in_bit.value ^ prev_q);
      default:   decoded = in_bit.value;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      prev_q   <= 1'b0;
      strobe_q <= 1'b0;
      value_q  <= 1'b0;
    end else begin
      strobe_q <= in_bit.strobe;
      if (in_bit.strobe) begin
        prev_q  <= in_bit.value;
        value_q <= decoded;
      end
    end
  end

  assign out_bit.strobe = strobe_q;
  assign out_bit.value  = value_q;

endmodule

// ==== derandomizer.sv ====
`timescale 1ns/100ps

module derandomizer (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          data_invert,
  input  pcm_decoder_pkg::derand_mode_t derand_mode,
  input  pcm_decoder_pkg::pcm_bit_s     in_bit,
  output pcm_decoder_pkg::pcm_bit_s     out_bit
);

  import pcm_decoder_pkg::*;

  localparam int IDX_W = $clog2(DERAND_HIST_LEN);

  logic [DERAND_HIST_LEN-1:0] hist_q;
  logic [IDX_W-1:0]           tap_a;
  logic [IDX_W-1:0]           tap_b;
  logic                       descrambled;
  logic                       strobe_q;
  logic                       value_q;

  // ------------------------------------------------------------------------
  // Tap selection, index 0 is the newest stored bit
  // ------------------------------------------------------------------------
  always_comb begin
    case (derand_mode)
      DERAND_RNRZ9: begin
        tap_a = IDX_W'(8);
        tap_b = IDX_W'(4);
      end
      DERAND_RNRZ11: begin
        tap_a = IDX_W'(10);
        tap_b = IDX_W'(8);
      end
      DERAND_RNRZ17: begin
        tap_a = IDX_W'(16);
        tap_b = IDX_W'(13);
      end
      DERAND_RNRZ23: begin
        tap_a = IDX_W'(22);
        tap_b = IDX_W'(17);
      end
      // RNRZ15 and the unused codes
      default: begin
        tap_a = IDX_W'(14);
        tap_b = IDX_W'(13);
      end
    endcase
  end

  always_comb begin
    if (derand_mode == DERAND_OFF) begin
      descrambled = in_bit.value;
    end else begin
      descrambled = in_bit.value ^ hist_q[tap_a] ^ hist_q[tap_b];
    end
  end

  // ------------------------------------------------------------------------
  // History and output polarity
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hist_q   <= '0;
      strobe_q <= 1'b0;
      value_q  <= 1'b0;
    end else begin
      strobe_q <= in_bit.strobe;
      if (in_bit.strobe) begin
        // Self-synchronizing, so the scrambled input feeds the history
        hist_q  <= {hist_q[DERAND_HIST_LEN-2:0], in_bit.value};
        value_q <= descrambled ^ data_invert;
      end
    end
  end

  assign out_bit.strobe = strobe_q;
  assign out_bit.value  = value_q;

endmodule

// ==== symbol_clock_gen.sv ====
`timescale 1ns/100ps

module symbol_clock_gen (
  input  logic clk,
  input  logic reset,
  input  logic symb_clk_en,
  input  logic symb_clk_2x_en,
  input  logic bit_tick,
  input  logic biphase,
  input  logic clock_select,
  output logic clk_en_out,
  output logic symb_clk
);

  logic symbol_clk_q;
  logic clk_set;
  logic clk_toggle;

  // ------------------------------------------------------------------------
  // Output clock enable
  // ------------------------------------------------------------------------
  always_comb begin
    if (biphase) begin
      clk_en_out = bit_tick;
    end else if (clock_select) begin
      clk_en_out = symb_clk_en;
    end else begin
      clk_en_out = symb_clk_2x_en;
    end
  end

  // ------------------------------------------------------------------------
  // Symbol clock
  // ------------------------------------------------------------------------

  // Set on the bit boundary, toggle at the half bit
  assign clk_set    = biphase ? bit_tick : symb_clk_en;
  assign clk_toggle = biphase ? symb_clk_en : symb_clk_2x_en;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      symbol_clk_q <= 1'b0;
    end else if (clk_set) begin
      symbol_clk_q <= 1'b1;
    end else if (clk_toggle) begin
      symbol_clk_q <= ~symbol_clk_q;
    end
  end

  assign symb_clk = clock_select ? symbol_clk_q : symb_clk_2x_en;

endmodule

// ==== pcm_decoder.sv ====
`timescale 1ns/100ps

module pcm_decoder (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       cs,
  input  pcm_decoder_pkg::byte_en_t  wr,
  input  pcm_decoder_pkg::bus_addr_t addr,
  input  pcm_decoder_pkg::bus_data_t din,
  output pcm_decoder_pkg::bus_data_t dout,
  input  logic                       symb_clk_en,
  input  logic                       symb_clk_2x_en,
  input  logic                       symb,
  output logic                       data_out,
  output logic                       data_en,
  output logic                       clk_en_out,
  output logic                       symb_clk,
  output logic                       fifo_reset,
  output logic [1:0]                 clk_phase,
  output logic [1:0]                 input_select
);

  import pcm_decoder_pkg::*;

  decoder_config_s cfg;
  pcm_bit_s        nrz_bit;
  pcm_bit_s        dec_bit;
  pcm_bit_s        out_bit;
  logic            bit_tick;

  // ------------------------------------------------------------------------
  // Configuration
  // ------------------------------------------------------------------------
  pcm_decoder_regs u_regs (
    .clk   (clk),
    .reset (reset),
    .cs    (cs),
    .wr    (wr),
    .addr  (addr),
    .din   (din),
    .dout  (dout),
    .cfg   (cfg)
  );

  // Passed straight through for the front end and output FIFO
  assign fifo_reset   = cfg.fifo_reset;
  assign clk_phase    = cfg.clk_phase;
  assign input_select = cfg.input_select;

  // ------------------------------------------------------------------------
  // Data path, one register per stage
  // ------------------------------------------------------------------------
  biphase_to_nrz u_biphase (
    .clk         (clk),
    .reset       (reset),
    .symb_clk_en (symb_clk_en),
    .biphase     (cfg.biphase),
    .symb        (symb),
    .nrz_bit     (nrz_bit),
    .bit_tick    (bit_tick)
  );

  mark_space_decode u_mark_space (
    .clk       (clk),
    .reset     (reset),
    .code_mode (cfg.code_mode),
    .in_bit    (nrz_bit),
    .out_bit   (dec_bit)
  );

  derandomizer u_derand (
    .clk         (clk),
    .reset       (reset),
    .data_invert (cfg.data_invert),
    .derand_mode (cfg.derand_mode),
    .in_bit      (dec_bit),
    .out_bit     (out_bit)
  );

  assign data_out = out_bit.value;
  assign data_en  = out_bit.strobe;

  // ------------------------------------------------------------------------
  // Output clocking
  // ------------------------------------------------------------------------
  symbol_clock_gen u_clock_gen (
    .clk            (clk),
    .reset          (reset),
    .symb_clk_en    (symb_clk_en),
    .symb_clk_2x_en (symb_clk_2x_en),
    .bit_tick       (bit_tick),
    .biphase        (cfg.biphase),
    .clock_select   (cfg.clock_select),
    .clk_en_out     (clk_en_out),
    .symb_clk       (symb_clk)
  );

endmodule

// ==== tb_pcm_decoder_sva.sv ====
`timescale 1ns/100ps

module tb_pcm_decoder_sva (
  input logic clk,
  input logic reset,
  input logic symb_clk_en,
  input logic biphase,
  input logic data_en,
  input logic clk_en_out,
  input logic symb_clk,
  input logic fifo_reset
);

  // Spaced input strobes give spaced output strobes
  assert property (@(posedge clk) disable iff (reset)
    !($past(symb_clk_en, 3) && $past(symb_clk_en, 4)) |-> !(data_en && $past(data_en)))
    else $error("data_en high on two cycles in a row from spaced strobes");

  // Three register stages with biphase off
  assert property (@(posedge clk) disable iff (reset)
    (symb_clk_en && !biphase) |-> ##3 data_en)
    else $error("data_en did not follow symb_clk_en by 3 cycles");

  assert property (@(posedge clk)
    reset |-> !(data_en || clk_en_out || symb_clk || fifo_reset))
    else $error("output high during reset");

endmodule

// ==== tb_pcm_decoder.sv ====
`timescale 1ns/100ps

module tb_pcm_decoder;

  import pcm_decoder_pkg::*;

  localparam int TIMEOUT_CYCLES = 40000;

  logic         clk;
  logic         reset;
  logic         cs;
  byte_en_t     wr;
  bus_addr_t    addr;
  bus_data_t    din;
  bus_data_t    dout;
  logic         symb_clk_en;
  logic         symb_clk_2x_en;
  logic         symb;
  logic         data_out;
  logic         data_en;
  logic         clk_en_out;
  logic         symb_clk;
  logic         fifo_reset;
  logic [1:0]   clk_phase;
  logic [1:0]   input_select;

  // Bits in flight and the cycle of the strobe that completed each one
  logic [1:0]   sent_q[$];
  int           cycle_q[$];
  int           cycle_count = 0;
  int           check_count = 0;
  int           error_count = 0;
  int           test_count = 0;
  int           test_checks = 0;
  int           test_errors = 0;
  logic [31:0]  lcg_state = 32'hd86150f9;
  bus_data_t    rd_data;

  // Model state that mirrors the configuration written over the bus
  code_mode_t   m_code;
  derand_mode_t m_derand;
  logic         m_invert;
  logic         m_biphase;
  logic         m_clksel;
  logic         prev_model;
  logic [22:0]  hist_model;
  logic         phase_model;
  logic         sclk_model;
  logic         tick_model;
  logic         clock_check_on;
  logic [1:0]   halves;
  logic [2:0]   ref_out;
  int           start_cycle;

  pcm_decoder UUT (.*);

  bind pcm_decoder tb_pcm_decoder_sva u_sva (
    .clk         (clk),
    .reset       (reset),
    .symb_clk_en (symb_clk_en),
    .biphase     (cfg.biphase),
    .data_en     (data_en),
    .clk_en_out  (clk_en_out),
    .symb_clk    (symb_clk),
    .fifo_reset  (fifo_reset)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(negedge clk) cycle_count <= cycle_count + 1;

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) @(negedge clk);
    $display("Timeout: simulation still running after %0d cycles", TIMEOUT_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Returns {nrz bit, differential decoded bit, output bit}
  function automatic logic [2:0] reference_bit(input logic [1:0] pair, input logic biphase,
      input code_mode_t code, input derand_mode_t mode, input logic invert,
      input logic prev, input logic [22:0] hist);
    logic nrz;
    logic diff;
    logic descr;
    // First half of a biphase-L symbol carries the level
    nrz = biphase ? pair[1] : pair[0];
    diff = (code == CODE_NRZM) ? (nrz ^ prev) : (code == CODE_NRZS) ? ~(nrz ^ prev) : nrz;
    case (mode)
      3'd0:    descr = diff;
      3'd2:    descr = diff ^ hist[8] ^ hist[4];
      3'd3:    descr = diff ^ hist[10] ^ hist[8];
      3'd4:    descr = diff ^ hist[16] ^ hist[13];
      3'd5:    descr = diff ^ hist[22] ^ hist[17];
      default: descr = diff ^ hist[14] ^ hist[13];
    endcase
    return {nrz, diff, descr ^ invert};
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
      input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  always @(negedge clk) begin
    if (!reset && data_en) begin
      if (sent_q.size() == 0) begin
        error_count++;
        $display("Unexpected data_en at %0t with no bit outstanding", $time);
      end else begin
        halves = sent_q.pop_front();
        start_cycle = cycle_q.pop_front();
        ref_out = reference_bit(halves, m_biphase, m_code, m_derand, m_invert,
                                prev_model, hist_model);
        prev_model = ref_out[2];
        hist_model = {hist_model[21:0], ref_out[1]};
        check_value(data_out, ref_out[0], "data_out");
        check_value(cycle_count - start_cycle, 3, "data_en latency");
      end
    end
  end

  // Clock output model running from the same strobes
  always @(negedge clk) begin
    if (reset) begin
      phase_model = 1'b0;
      sclk_model = 1'b0;
    end else begin
      tick_model = symb_clk_en && (!m_biphase || phase_model);
      if (clock_check_on) begin
        check_value(clk_en_out,
                    m_biphase ? tick_model : (m_clksel ? symb_clk_en : symb_clk_2x_en),
                    "clk_en_out");
        check_value(symb_clk, m_clksel ? sclk_model : symb_clk_2x_en, "symb_clk");
      end
      if (m_biphase ? tick_model : symb_clk_en) begin
        sclk_model = 1'b1;
      end else if (m_biphase ? symb_clk_en : symb_clk_2x_en) begin
        sclk_model = ~sclk_model;
      end
      phase_model = m_biphase && (symb_clk_en ? !phase_model : phase_model);
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  task automatic bus_write(input bus_addr_t a, input bus_data_t d, input byte_en_t lanes);
    @(posedge clk);
    cs <= 1'b1;
    wr <= lanes;
    addr <= a;
    din <= d;
    @(posedge clk);
    cs <= 1'b0;
    wr <= '0;
  endtask

  task automatic bus_read(input bus_addr_t a, output bus_data_t d);
    @(posedge clk);
    cs <= 1'b1;
    addr <= a;
    @(negedge clk);
    d = dout;
    @(posedge clk);
    cs <= 1'b0;
  endtask

  // Stop the strobes and let the pipeline empty
  task automatic drain();
    @(posedge clk);
    symb_clk_en <= 1'b0;
    symb_clk_2x_en <= 1'b0;
    while (sent_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
  endtask

  task automatic write_config(input logic bph, input code_mode_t code,
      input derand_mode_t mode, input logic inv, input logic csel);
    drain();
    bus_write(DEC_CONTROL_ADDR, {22'd0, csel, inv, 1'b0, mode, 1'b0, bph, code}, 4'hf);
    m_biphase = bph;
    m_code = code;
    m_derand = mode;
    m_invert = inv;
    m_clksel = csel;
  endtask

  // One symb_clk_en strobe with symb_clk_2x_en at twice its rate
  task automatic strobe_symb(input logic level, input int gap, input logic completes,
      input logic [1:0] pair);
    @(posedge clk);
    symb <= level;
    symb_clk_en <= 1'b1;
    symb_clk_2x_en <= 1'b1;
    if (completes) begin
      sent_q.push_back(pair);
      cycle_q.push_back(cycle_count);
    end
    for (int i = 1; i < gap; i++) begin
      @(posedge clk);
      symb_clk_en <= 1'b0;
      symb_clk_2x_en <= (i == gap / 2);
    end
  endtask

  task automatic send_random(input int count, input int gap);
    logic value;
    for (int n = 0; n < count; n++) begin
      lcg_state = lcg_next(lcg_state);
      value = lcg_state[31];
      if (m_biphase) begin
        strobe_symb(value, gap, 1'b0, 2'b00);
        strobe_symb(~value, gap, 1'b1, {value, ~value});
      end else begin
        strobe_symb(value, gap, 1'b1, {value, value});
      end
    end
  endtask

  task automatic finish_test(input string name);
    drain();
    test_count++;
    $display("Test %0d %s: %0d checks, %0d errors", test_count, name,
             check_count - test_checks, error_count - test_errors);
    test_checks = check_count;
    test_errors = error_count;
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  initial begin
    $timeformat(-9, 1, " ns", 0);
    reset = 1'b1;
    cs = 1'b0;
    wr = '0;
    addr = '0;
    din = '0;
    symb_clk_en = 1'b0;
    symb_clk_2x_en = 1'b0;
    symb = 1'b0;
    {m_biphase, m_code, m_derand, m_invert, m_clksel} = '0;
    prev_model = 1'b0;
    hist_model = '0;
    clock_check_on = 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    bus_write(DEC_CONTROL_ADDR, 32'hffff_ffff, 4'hf);
    bus_read(DEC_CONTROL_ADDR, rd_data);
    check_value(rd_data, 32'h0103_3377, "control readback");
    check_value({fifo_reset, clk_phase, input_select}, 5'h1f, "pass-through fields");
    // Lane 1 keeps its ones
    bus_write(DEC_CONTROL_ADDR, 32'h0002_0000, 4'b1101);
    bus_read(DEC_CONTROL_ADDR, rd_data);
    check_value(rd_data, 32'h0002_3300, "byte-lane readback");
    check_value({fifo_reset, clk_phase, input_select}, 5'h0e, "pass-through fields");
    bus_write(13'h004, 32'hffff_ffff, 4'hf);
    bus_read(13'h004, rd_data);
    check_value(rd_data, 32'h0, "unmapped readback");
    bus_read(DEC_CONTROL_ADDR, rd_data);
    check_value(rd_data, 32'h0002_3300, "control after unmapped write");
    finish_test("register access");

    write_config(1'b0, CODE_NRZL, DERAND_OFF, 1'b0, 1'b0);
    send_random(200, 4);
    send_random(200, 1);
    finish_test("nrz-l passthrough");

    for (int inv = 0; inv < 2; inv++) begin
      write_config(1'b0, CODE_NRZM, DERAND_OFF, inv[0], 1'b0);
      send_random(300, 4);
      write_config(1'b0, CODE_NRZS, DERAND_OFF, inv[0], 1'b0);
      send_random(300, 4);
    end
    finish_test("nrz-m and nrz-s");

    for (int mode = 1; mode <= 5; mode++) begin
      write_config(1'b0, CODE_NRZL, derand_mode_t'(mode), 1'b0, 1'b0);
      send_random(400, 4);
    end
    finish_test("rnrz derandomizer");

    write_config(1'b1, CODE_NRZL, DERAND_OFF, 1'b0, 1'b0);
    send_random(150, 4);
    send_random(100, 1);
    write_config(1'b1, CODE_NRZM, DERAND_RNRZ15, 1'b1, 1'b0);
    send_random(100, 4);
    finish_test("biphase-l");

    clock_check_on = 1'b1;
    write_config(1'b0, CODE_NRZL, DERAND_OFF, 1'b0, 1'b0);
    send_random(80, 4);
    write_config(1'b0, CODE_NRZL, DERAND_OFF, 1'b0, 1'b1);
    send_random(80, 4);
    write_config(1'b1, CODE_NRZL, DERAND_OFF, 1'b0, 1'b1);
    send_random(80, 4);
    clock_check_on = 1'b0;
    finish_test("clock outputs");

    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
             error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== pcm_decoder.f ====
pcm_decoder_pkg.sv
pcm_decoder_regs.sv
biphase_to_nrz.sv
mark_space_decode.sv
derandomizer.sv
symbol_clock_gen.sv
pcm_decoder.sv
tb_pcm_decoder_sva.sv
tb_pcm_decoder.sv
